//--- lcd_ctrl.f
src/lcd_pkg.sv
src/lcd_cmd_if.sv
src/lcd_init_seq.sv
src/lcd_text_writer.sv
src/lcd_bus_arbiter.sv
src/lcd_bus_driver.sv
src/lcd_ctrl_top.sv
test/lcd_ctrl_tb.sv

//--- Bender.yml
package:
  name: lcd_ctrl

sources:
  - src/lcd_pkg.sv
  - src/lcd_cmd_if.sv
  - src/lcd_init_seq.sv
  - src/lcd_text_writer.sv
  - src/lcd_bus_arbiter.sv
  - src/lcd_bus_driver.sv
  - src/lcd_ctrl_top.sv
  - target: test
    files:
      - test/lcd_ctrl_tb.sv

//--- test/lcd_ctrl_tb.sv
`timescale 1ns/1ps

module lcd_ctrl_tb;

  localparam int POWER_ON_CYCLES  = 50;
  localparam int WAKE_GAP_CYCLES  = 10;
  localparam int E_CYCLES         = 3;
  localparam int CMD_WAIT_CYCLES  = 4;
  localparam int LONG_WAIT_CYCLES = 12;
  localparam int FIFO_DEPTH       = 4;
  localparam int WAIT_LIMIT       = 2000; // cycles per wait loop

  localparam int T_INIT    = 0;
  localparam int T_CHARS   = 1;
  localparam int T_WRAP    = 2;
  localparam int T_NEWLINE = 3;
  localparam int T_CREDITS = 4;
  localparam int T_BUS     = 5;

  logic       clk;
  logic       rst;
  logic       char_valid;
  logic [7:0] char_data;
  logic       char_credit;
  logic       ready;
  logic [7:0] lcd_d;
  logic       lcd_e;
  logic       lcd_rw;
  logic       lcd_rs;

  integer     seed;
  logic [8:0] obs_q [$]; // {rs, data} per enable pulse
  logic [8:0] exp_q [$];
  int         kind_q [$]; // test that owns each expected transfer
  int         chk [6];
  int         err [6];
  int         pushed;
  int         returned;
  int         credits;
  int         cyc;
  int         first_rise;
  int         ready_obs;
  int         e_width;
  int         wraps;
  int         newlines;
  bit         e_q;
  bit         ready_q;
  bit         timed_out;
  logic [8:0] e_hold;
  bit         m_line;
  int         m_col;

  lcd_ctrl_top #(
    .POWER_ON_CYCLES (POWER_ON_CYCLES),
    .WAKE_GAP_CYCLES (WAKE_GAP_CYCLES),
    .E_CYCLES        (E_CYCLES),
    .CMD_WAIT_CYCLES (CMD_WAIT_CYCLES),
    .LONG_WAIT_CYCLES(LONG_WAIT_CYCLES),
    .FIFO_DEPTH      (FIFO_DEPTH)
  ) lcd_ctrl_top_i (
    .clk        (clk),
    .rst        (rst),
    .char_valid (char_valid),
    .char_data  (char_data),
    .char_credit(char_credit),
    .ready      (ready),
    .lcd_d      (lcd_d),
    .lcd_e      (lcd_e),
    .lcd_rw     (lcd_rw),
    .lcd_rs     (lcd_rs)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic string test_name(input int id);
    case (id)
      T_INIT:    return "init";
      T_CHARS:   return "chars";
      T_WRAP:    return "wrap";
      T_NEWLINE: return "newline";
      T_CREDITS: return "credits";
      default:   return "bus";
    endcase
  endfunction

  task automatic compare_value(input int id, input int unsigned expv, input int unsigned actv);
    chk[id]++;
    assert (expv == actv) else begin
      err[id]++;
      $display("mismatch %s: expected 0x%0h, actual 0x%0h", test_name(id), expv, actv);
    end
  endtask

  task automatic require(input int id, input bit cond, input string what);
    chk[id]++;
    assert (cond) else begin
      err[id]++;
      $display("error %s: %s", test_name(id), what);
    end
  endtask

  task automatic report_test(input int id);
    $display("test %-8s %0d checks, %0d errors", test_name(id), chk[id], err[id]);
  endtask

  // reference model of the cursor, 0xC0 is line 2 and 0x80 line 1
  task automatic model_byte(input logic [7:0] b);
    if (b == 8'h0A) begin
      exp_q.push_back({1'b0, m_line ? 8'h80 : 8'hC0});
      kind_q.push_back(T_NEWLINE);
      m_line = !m_line;
      m_col  = 0;
      newlines++;
    end else begin
      exp_q.push_back({1'b1, b});
      kind_q.push_back(T_CHARS);
      m_col++;
      if (m_col == 16) begin
        exp_q.push_back({1'b0, m_line ? 8'h80 : 8'hC0});
        kind_q.push_back(T_WRAP);
        m_line = !m_line;
        m_col  = 0;
        wraps++;
      end
    end
  endtask

  task automatic next_host_cycle();
    @(posedge clk);
    #2;
    if (char_credit) credits++;
    char_valid = 1'b0;
  endtask

  task automatic send_bytes(input int count, input bit with_newline);
    int sent;
    int stall;
    int r;
    logic [7:0] b;
    sent  = 0;
    stall = 0;
    while (sent < count) begin
      next_host_cycle();
      if (credits > 0 && ($random(seed) & 1) == 0) begin // random gap
        r = $random(seed);
        if (with_newline && (r & 7) == 0) b = 8'h0A;
        else b = 8'h20 + ((r >> 8) & 63);
        char_valid = 1'b1;
        char_data  = b;
        credits--;
        pushed++;
        sent++;
        stall = 0;
        model_byte(b);
      end else begin
        stall++;
        if (stall > WAIT_LIMIT) begin
          timed_out = 1'b1;
          require(T_CREDITS, 1'b0, "timeout waiting for a credit to push the next byte");
          break;
        end
      end
    end
  endtask

  // bus monitor, sampled mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      cyc++;
      require(T_BUS, lcd_rw == 1'b0, "lcd_rw went high");
      if (char_credit) returned++;
      require(T_CREDITS, returned <= pushed, "credit returned with no byte outstanding");
      if (lcd_e && !e_q) begin
        obs_q.push_back({lcd_rs, lcd_d});
        if (first_rise == 0) first_rise = cyc;
        e_width = 1;
        e_hold  = {lcd_rs, lcd_d};
      end else if (lcd_e) begin
        e_width++;
        require(T_BUS, {lcd_rs, lcd_d} == e_hold, "lcd_rs or lcd_d changed while lcd_e was high");
      end else if (e_q) begin
        compare_value(T_BUS, E_CYCLES, e_width);
      end
      if (ready && !ready_q) ready_obs = obs_q.size();
      if (ready_q && !ready) require(T_INIT, 1'b0, "ready fell after initialization");
      e_q     = lcd_e;
      ready_q = ready;
    end
  end

  initial begin
    logic [7:0] init_list [7];
    int n;
    int i;
    int tc;
    int te;
    rst        = 1'b1;
    char_valid = 1'b0;
    char_data  = 8'h00;
    seed       = 34;
    credits    = FIFO_DEPTH;
    init_list  = '{8'h30, 8'h30, 8'h30, 8'h38, 8'h0C, 8'h01, 8'h06};
    repeat (8) @(posedge clk);
    #2;
    require(T_BUS, {lcd_e, lcd_rw, lcd_rs, ready, char_credit} == 5'b0 && lcd_d == 8'h00,
            "outputs not at their reset values");
    rst = 1'b0;

    n = 0;
    while (!ready && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    @(posedge clk); // let the monitor finish this cycle
    if (!ready) begin
      timed_out = 1'b1;
      require(T_INIT, 1'b0, "timeout waiting for ready after power-on");
    end else begin
      require(T_INIT, first_rise > POWER_ON_CYCLES, "lcd_e rose within the power-on delay");
      compare_value(T_INIT, 7, ready_obs);
      for (i = 0; i < 7 && obs_q.size() > 0; i++) begin
        compare_value(T_INIT, {1'b0, init_list[i]}, obs_q.pop_front());
      end
    end
    report_test(T_INIT);

    if (!timed_out) begin
      send_bytes(40, 1'b0); // forces two wraps
      if (!timed_out) send_bytes(300, 1'b1);
      n = 0;
      next_host_cycle();
      while ((credits != FIFO_DEPTH || obs_q.size() < exp_q.size()) && n < WAIT_LIMIT) begin
        next_host_cycle();
        n++;
      end
      if (n >= WAIT_LIMIT) begin
        timed_out = 1'b1;
        require(T_CREDITS, 1'b0, "timeout waiting for the queue to drain");
      end
      for (i = 0; i < exp_q.size(); i++) begin
        if (i < obs_q.size()) compare_value(kind_q[i], exp_q[i], obs_q[i]);
        else require(kind_q[i], 1'b0, "expected transfer never appeared on the bus");
      end
      compare_value(T_CHARS, exp_q.size(), obs_q.size());
      require(T_WRAP, wraps > 0, "burst produced no line wrap");
      require(T_NEWLINE, newlines > 0, "burst held no newline");
      compare_value(T_CREDITS, pushed, returned);
    end
    report_test(T_CHARS);
    report_test(T_WRAP);
    report_test(T_NEWLINE);
    report_test(T_CREDITS);
    report_test(T_BUS);

    tc = 0;
    te = 0;
    for (i = 0; i < 6; i++) begin
      tc += chk[i];
      te += err[i];
    end
    $display("summary: %0d checks, %0d errors, %0d bytes pushed", tc, te, pushed);
    if (te == 0 && !timed_out) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- src/lcd_ctrl_top.sv
`timescale 1ns/1ps

module lcd_ctrl_top #(
  parameter int unsigned POWER_ON_CYCLES  = 750_000, // 15 ms at 50 MHz
  parameter int unsigned WAKE_GAP_CYCLES  = 205_000, // 4.1 ms
  parameter int unsigned E_CYCLES         = 12,
  parameter int unsigned CMD_WAIT_CYCLES  = 2_000,   // 40 us
  parameter int unsigned LONG_WAIT_CYCLES = 82_000,  // 1.64 ms
  parameter int unsigned FIFO_DEPTH       = 16
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       char_valid,
  input  logic [7:0] char_data,
  output logic       char_credit,
  output logic       ready,
  output logic [7:0] lcd_d,
  output logic       lcd_e,
  output logic       lcd_rw,
  output logic       lcd_rs
);

  lcd_cmd_if init_bus ();
  lcd_cmd_if text_bus ();
  lcd_cmd_if lcd_bus ();

  lcd_init_seq #(
    .POWER_ON_CYCLES(POWER_ON_CYCLES),
    .WAKE_GAP_CYCLES(WAKE_GAP_CYCLES)
  ) lcd_init_seq_i (
    .clk      (clk),
    .rst      (rst),
    .bus      (init_bus.src),
    .init_done(ready)
  );

  lcd_text_writer #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) lcd_text_writer_i (
    .clk        (clk),
    .rst        (rst),
    .char_valid (char_valid),
    .char_data  (char_data),
    .char_credit(char_credit),
    .bus        (text_bus.src)
  );

  lcd_bus_arbiter lcd_bus_arbiter_i (
    .clk      (clk),
    .rst      (rst),
    .init_done(ready),
    .init_bus (init_bus.sink),
    .text_bus (text_bus.sink),
    .lcd_bus  (lcd_bus.src)
  );

  lcd_bus_driver #(
    .E_CYCLES        (E_CYCLES),
    .CMD_WAIT_CYCLES (CMD_WAIT_CYCLES),
    .LONG_WAIT_CYCLES(LONG_WAIT_CYCLES)
  ) lcd_bus_driver_i (
    .clk   (clk),
    .rst   (rst),
    .bus   (lcd_bus.sink),
    .lcd_d (lcd_d),
    .lcd_e (lcd_e),
    .lcd_rs(lcd_rs),
    .lcd_rw(lcd_rw)
  );

endmodule

//--- src/lcd_bus_driver.sv
`timescale 1ns/1ps

module lcd_bus_driver #(
  parameter int unsigned E_CYCLES         = 12,
  parameter int unsigned CMD_WAIT_CYCLES  = 2_000,
  parameter int unsigned LONG_WAIT_CYCLES = 82_000
) (
  input  logic               clk,
  input  logic               rst,
  lcd_cmd_if.sink            bus,
  output lcd_pkg::lcd_byte_t lcd_d,
  output logic               lcd_e,
  output logic               lcd_rs,
  output logic               lcd_rw
);
  import lcd_pkg::*;

  localparam int unsigned WAIT_MAX =
    (LONG_WAIT_CYCLES > CMD_WAIT_CYCLES) ? LONG_WAIT_CYCLES : CMD_WAIT_CYCLES;
  localparam int unsigned MAX_CNT = (E_CYCLES > WAIT_MAX) ? E_CYCLES : WAIT_MAX;
  localparam int unsigned CW = $clog2(MAX_CNT + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PULSE,
    ST_WAIT
  } state_t;

  state_t        state;
  logic [CW-1:0] cnt;
  logic          is_long;
  logic          long_q;
  logic          done_q;

  // clear and return home need the long execution time
  assign is_long  = !bus.rs && (bus.data == CMD_CLEAR || bus.data == 8'h02);
  assign lcd_rw   = 1'b0; // write only
  assign bus.done = done_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= ST_IDLE;
      cnt    <= '0;
      long_q <= 1'b0;
      done_q <= 1'b0;
      lcd_d  <= '0;
      lcd_e  <= 1'b0;
      lcd_rs <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (bus.valid && !done_q) begin // source updates after done
            lcd_d  <= bus.data;
            lcd_rs <= bus.rs;
            lcd_e  <= 1'b1;
            long_q <= is_long;
            cnt    <= CW'(E_CYCLES - 1);
            state  <= ST_PULSE;
          end
        end
        ST_PULSE: begin
          if (cnt == '0) begin
            lcd_e <= 1'b0;
            cnt   <= long_q ? CW'(LONG_WAIT_CYCLES - 1) : CW'(CMD_WAIT_CYCLES - 1);
            state <= ST_WAIT;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        default: begin
          if (cnt == '0) begin
            done_q <= 1'b1;
            state  <= ST_IDLE;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
      endcase
    end
  end

endmodule

//--- src/lcd_bus_arbiter.sv
`timescale 1ns/1ps

module lcd_bus_arbiter (
  input  logic    clk,
  input  logic    rst,
  input  logic    init_done,
  lcd_cmd_if.sink init_bus,
  lcd_cmd_if.sink text_bus,
  lcd_cmd_if.src  lcd_bus
);

  logic locked;
  logic owner_text;
  logic sel_text;
  logic use_text;

  // init has priority, text waits for init_done
  assign sel_text = init_done && text_bus.valid && !init_bus.valid;
  assign use_text = locked ? owner_text : sel_text;

  assign lcd_bus.valid = use_text ? text_bus.valid : init_bus.valid;
  assign lcd_bus.rs    = use_text ? text_bus.rs    : init_bus.rs;
  assign lcd_bus.data  = use_text ? text_bus.data  : init_bus.data;

  // completion only to the owner
  assign init_bus.done = lcd_bus.done && !owner_text;
  assign text_bus.done = lcd_bus.done && owner_text;

  always_ff @(posedge clk) begin
    if (rst) begin
      locked     <= 1'b0;
      owner_text <= 1'b0;
    end else if (locked) begin
      if (lcd_bus.done) begin
        locked <= 1'b0;
      end
    end else if (lcd_bus.valid) begin
      locked     <= 1'b1; // driver takes it this edge
      owner_text <= sel_text;
    end
  end

endmodule

//--- src/lcd_text_writer.sv
`timescale 1ns/1ps

module lcd_text_writer #(
  parameter int unsigned FIFO_DEPTH = 16
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               char_valid,
  input  lcd_pkg::lcd_byte_t char_data,
  output logic               char_credit,
  lcd_cmd_if.src             bus
);
  import lcd_pkg::*;

  localparam int unsigned AW = $clog2(FIFO_DEPTH);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CHAR,
    ST_ADDR
  } state_t;

  lcd_byte_t   mem [FIFO_DEPTH];
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        full;
  logic        empty;
  logic        push;
  logic        pop;
  lcd_byte_t   head;

  state_t      state;
  logic        line; // 0 top, 1 bottom
  logic [4:0]  col;
  logic [4:0]  col_next;
  lcd_byte_t   jump_addr;
  logic        out_rs;
  lcd_byte_t   out_data;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign push  = char_valid && !full; // push beyond credit is dropped
  assign pop   = (state == ST_IDLE) && !empty;
  assign head  = mem[rd_ptr[AW-1:0]];

  assign col_next  = col + 5'd1;
  assign jump_addr = line ? CMD_SET_ADDR : (CMD_SET_ADDR | {1'b0, LINE2_ADDR}); // other line

  assign bus.valid = (state != ST_IDLE);
  assign bus.rs    = out_rs;
  assign bus.data  = out_data;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[AW-1:0]] <= char_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      char_credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      char_credit <= pop; // slot freed
    end
  end

  // transfer payload
  always_ff @(posedge clk) begin
    if (pop) begin
      out_rs   <= (head != CHAR_NEWLINE);
      out_data <= (head == CHAR_NEWLINE) ? jump_addr : head;
    end else if (state == ST_CHAR && bus.done && col_next == LINE_LEN) begin
      out_rs   <= 1'b0;
      out_data <= jump_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      line  <= 1'b0;
      col   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (pop) begin
            state <= (head == CHAR_NEWLINE) ? ST_ADDR : ST_CHAR;
          end
        end
        ST_CHAR: begin
          if (bus.done) begin
            if (col_next == LINE_LEN) begin
              state <= ST_ADDR; // line full, wrap
            end else begin
              col   <= col_next;
              state <= ST_IDLE;
            end
          end
        end
        default: begin
          if (bus.done) begin
            line  <= ~line;
            col   <= '0;
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

endmodule

//--- src/lcd_init_seq.sv
`timescale 1ns/1ps

module lcd_init_seq #(
  parameter int unsigned POWER_ON_CYCLES = 750_000,
  parameter int unsigned WAKE_GAP_CYCLES = 205_000
) (
  input  logic   clk,
  input  logic   rst,
  lcd_cmd_if.src bus,
  output logic   init_done
);
  import lcd_pkg::*;

  localparam int unsigned MAX_CNT =
    (POWER_ON_CYCLES > WAKE_GAP_CYCLES) ? POWER_ON_CYCLES : WAKE_GAP_CYCLES;
  localparam int unsigned CW = $clog2(MAX_CNT + 1);

  typedef enum logic [1:0] {
    ST_POWER,
    ST_REQ,
    ST_GAP,
    ST_DONE
  } state_t;

  state_t        state;
  logic [CW-1:0] cnt;
  logic [2:0]    step;

  // init commands are always instructions
  assign bus.valid = (state == ST_REQ);
  assign bus.rs    = 1'b0;
  assign bus.data  = init_cmd(step);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_POWER;
      cnt       <= CW'(POWER_ON_CYCLES - 1);
      step      <= '0;
      init_done <= 1'b0;
    end else begin
      case (state)
        ST_POWER, ST_GAP: begin
          if (cnt == '0) begin
            state <= ST_REQ;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        ST_REQ: begin
          if (bus.done) begin
            if (step == 3'(INIT_LEN - 1)) begin
              state     <= ST_DONE;
              init_done <= 1'b1; // entry mode finished
            end else begin
              step <= step + 3'd1;
              if (step < 3'(INIT_WAKES)) begin // wake needs idle gap
                state <= ST_GAP;
                cnt   <= CW'(WAKE_GAP_CYCLES - 1);
              end
            end
          end
        end
        default: begin
          state <= ST_DONE;
        end
      endcase
    end
  end

endmodule

//--- src/lcd_cmd_if.sv
`timescale 1ns/1ps

interface lcd_cmd_if;
  import lcd_pkg::*;

  logic      valid; // held until done
  logic      rs;
  lcd_byte_t data;
  logic      done;  // one-cycle completion pulse

  modport src (
    output valid,
    output rs,
    output data,
    input  done
  );

  modport sink (
    input  valid,
    input  rs,
    input  data,
    output done
  );

endinterface

//--- src/lcd_pkg.sv
package lcd_pkg;

  typedef logic [7:0] lcd_byte_t;

  // HD44780 instruction codes
  localparam lcd_byte_t CMD_WAKE     = 8'h30;
  localparam lcd_byte_t CMD_FUNC_SET = 8'h38; // 8-bit bus, 2 lines
  localparam lcd_byte_t CMD_DISP_ON  = 8'h0C; // cursor off
  localparam lcd_byte_t CMD_CLEAR    = 8'h01;
  localparam lcd_byte_t CMD_ENTRY    = 8'h06; // increment, no shift
  localparam lcd_byte_t CMD_SET_ADDR = 8'h80; // or'ed with ddram address

  // display geometry
  localparam logic [4:0] LINE_LEN   = 5'd16;
  localparam logic [6:0] LINE2_ADDR = 7'h40;

  localparam lcd_byte_t CHAR_NEWLINE = 8'h0A;

  // power-on command list
  localparam int unsigned INIT_LEN   = 7;
  localparam int unsigned INIT_WAKES = 3; // leading wake commands, each followed by a gap

  function automatic lcd_byte_t init_cmd(input logic [2:0] step);
    lcd_byte_t cmd;
    case (step)
      3'd0, 3'd1, 3'd2: cmd = CMD_WAKE;
      3'd3: cmd = CMD_FUNC_SET;
      3'd4: cmd = CMD_DISP_ON;
      3'd5: cmd = CMD_CLEAR;
      default: cmd = CMD_ENTRY;
    endcase
    return cmd;
  endfunction

endpackage
